//--- include/counting_filter_defs.svh
// ========================================================================
// Sizing of the counting filter. The bucket count must be a power of two
// and the bucket width must be at least three bits.
// ========================================================================

`ifndef COUNTING_FILTER_DEFS_SVH
`define COUNTING_FILTER_DEFS_SVH

// Number of buckets in the single bank
`define FILTER_N_BUCKETS 16
// Width of each bucket counter
`define FILTER_BUCKET_BITS 4
// Remove queue entries, also the number of credits a sender starts with
`define FILTER_REMOVE_DEPTH 4

`endif

//--- design/filter_types_pkg.sv
// ========================================================================
// Storage types of the filter. Widths follow the sizing macros.
// ========================================================================

`default_nettype none

`include "counting_filter_defs.svh"

package filter_types_pkg;

    // Bucket number, enough bits to address every bucket
    typedef logic [$clog2(`FILTER_N_BUCKETS)-1:0] t_bucket_idx;

    // Count held in one bucket
    typedef logic [`FILTER_BUCKET_BITS-1:0] t_bucket_value;

endpackage

`default_nettype wire

//--- design/update_pipe_pkg.sv
// ========================================================================
// Types of the read-modify-write update pipeline. The delta only has to
// span one own update plus two older ones in flight.
// ========================================================================

`default_nettype none

package update_pipe_pkg;

    // Stages from RAM read to RAM write
    localparam int UPD_STAGES = 3;

    // Signed net change of up to three updates, -3 to +3
    typedef logic signed [2:0] t_upd_delta;

    // Effect of a single update on its bucket
    function automatic t_upd_delta upd_step(input logic is_insert);
        return is_insert ? t_upd_delta'(1) : t_upd_delta'(-1);
    endfunction

endpackage

`default_nettype wire

//--- design/remove_queue.sv
// ========================================================================
// Circular queue of pending removes. Fullness is not checked here; the
// sender may only enqueue while it holds a credit.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_defs.svh"

module remove_queue
    import filter_types_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         remove_en,
    input  t_bucket_idx remove,
    input  wire         remove_take,
    output t_bucket_idx remove_head,
    output logic        remove_pending,
    output logic        remove_credit
);

    localparam int DEPTH = `FILTER_REMOVE_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    t_bucket_idx entries [0:DEPTH-1];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    // Pointers wrap explicitly so the depth need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (remove_en)
        begin
            entries[wr_ptr] <= remove;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            remove_credit <= 1'b0;
        end
        else
        begin
            if (remove_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (remove_take)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous enqueue and dequeue leave the occupancy alone
            if (remove_en && !remove_take)
            begin
                count <= count + 1'b1;
            end
            else if (!remove_en && remove_take)
            begin
                count <= count - 1'b1;
            end
            // One credit goes back the cycle after each dequeue
            remove_credit <= remove_take;
        end
    end

    assign remove_head = entries[rd_ptr];
    assign remove_pending = (count != '0);

endmodule

`default_nettype wire

//--- design/bucket_ram.sv
// ========================================================================
// One entry per bucket, one read and one write port. A write lands at the
// edge that samples it; a read in that same cycle returns the old entry.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_defs.svh"

module bucket_ram
    import filter_types_pkg::*;
#(
    parameter type T_PAYLOAD = logic,
    parameter T_PAYLOAD RESET_VALUE = T_PAYLOAD'(0)
)
(
    input  wire         clk,
    input  wire         reset,
    input  t_bucket_idx raddr,
    input  t_bucket_idx waddr,
    input  wire         wen,
    input  T_PAYLOAD    wdata,
    output T_PAYLOAD    rdata
);

    T_PAYLOAD mem [0:`FILTER_N_BUCKETS-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Every bucket starts from the same value
            for (int i = 0; i < `FILTER_N_BUCKETS; i++)
            begin
                mem[i] <= RESET_VALUE;
            end
            rdata <= RESET_VALUE;
        end
        else
        begin
            if (wen)
            begin
                mem[waddr] <= wdata;
            end
            // Read data is ready the cycle after the address
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- design/count_update_pipe.sv
// ========================================================================
// Read-modify-write of the bucket counters. Inserts always win the single
// update port. A selected update reads in stage 0 and writes in stage 2.
// The client must not overflow or underflow a bucket.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_defs.svh"

module count_update_pipe
    import filter_types_pkg::*;
    import update_pipe_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           insert_en,
    input  t_bucket_idx   insert,
    input  t_bucket_idx   remove_head,
    input  wire           remove_pending,
    output logic          remove_take,
    output logic          wr_en,
    output t_bucket_idx   wr_idx,
    output t_bucket_value wr_value,
    output logic          wr_is_zero
);

    localparam int WR_STAGE = UPD_STAGES - 1;

    // Stage UPD_STAGES is kept only so stage 1 can still see the update
    // that writes in the cycle its own read data arrives
    logic        upd_en [0:UPD_STAGES];
    t_bucket_idx upd_idx [0:UPD_STAGES];
    logic        upd_insert [0:UPD_STAGES];

    t_bucket_value rd_value;
    t_bucket_value rd_value_q;
    t_upd_delta delta;
    t_upd_delta delta_q;
    logic signed [`FILTER_BUCKET_BITS-1:0] delta_ext;

    // ====================================================================
    // Stage 0: arbitration and RAM read
    // ====================================================================

    assign remove_take = !insert_en && remove_pending;
    assign upd_en[0] = insert_en || remove_pending;
    assign upd_idx[0] = insert_en ? insert : remove_head;
    assign upd_insert[0] = insert_en;

    bucket_ram #(
        .T_PAYLOAD   (t_bucket_value),
        .RESET_VALUE (t_bucket_value'(0))
    ) counter_ram (
        .clk   (clk),
        .reset (reset),
        .raddr (upd_idx[0]),
        .waddr (wr_idx),
        .wen   (wr_en),
        .wdata (wr_value),
        .rdata (rd_value)
    );

    for (genvar p = 1; p <= UPD_STAGES; p++)
    begin : g_stage
        always_ff @(posedge clk)
        begin
            upd_idx[p] <= upd_idx[p-1];
            upd_insert[p] <= upd_insert[p-1];
            upd_en[p] <= reset ? 1'b0 : upd_en[p-1];
        end
    end

    // ====================================================================
    // Stage 1: delta of this update plus older ones the read missed
    // ====================================================================

    always_comb
    begin
        delta = upd_step(upd_insert[1]);
        for (int p = 2; p <= UPD_STAGES; p++)
        begin
            if (upd_en[p] && (upd_idx[p] == upd_idx[1]))
            begin
                delta = delta + upd_step(upd_insert[p]);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        delta_q <= delta;
        rd_value_q <= rd_value;
    end

    // Stage 2: the write, with the delta sign extended to the bucket width
    assign delta_ext = delta_q;
    assign wr_en = upd_en[WR_STAGE];
    assign wr_idx = upd_idx[WR_STAGE];
    assign wr_value = rd_value_q + t_bucket_value'(delta_ext);
    assign wr_is_zero = (wr_value == '0);

endmodule

`default_nettype wire

//--- design/bucket_lookup.sv
// ========================================================================
// Lookup port over a private RAM copy. A request's result appears two
// cycles later and reflects every write seen on the bus until then.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

module bucket_lookup
    import filter_types_pkg::*;
    import update_pipe_pkg::*;
#(
    parameter type T_PAYLOAD = logic,
    parameter T_PAYLOAD RESET_VALUE = T_PAYLOAD'(0)
)
(
    input  wire         clk,
    input  wire         reset,
    input  t_bucket_idx req,
    input  wire         wr_en,
    input  t_bucket_idx wr_idx,
    input  T_PAYLOAD    wr_data,
    output T_PAYLOAD    result
);

    localparam int LAST = UPD_STAGES - 1;

    // The request index is only needed up to the stage that reads the RAM
    t_bucket_idx lk_idx [0:LAST-1];
    logic        byp_en [1:LAST];
    T_PAYLOAD    byp_val [1:LAST];
    logic        hit [0:LAST-1];
    T_PAYLOAD    ram_data;

    assign lk_idx[0] = req;

    for (genvar p = 1; p < LAST; p++)
    begin : g_idx
        always_ff @(posedge clk)
        begin
            lk_idx[p] <= lk_idx[p-1];
        end
    end

    for (genvar p = 0; p < LAST; p++)
    begin : g_stage
        // A write on the bus now is newer than anything caught before
        assign hit[p] = wr_en && (wr_idx == lk_idx[p]);

        if (p == 0)
        begin : g_first
            always_ff @(posedge clk)
            begin
                byp_val[p+1] <= wr_data;
                byp_en[p+1] <= !reset && hit[p];
            end
        end
        else
        begin : g_rest
            always_ff @(posedge clk)
            begin
                byp_val[p+1] <= hit[p] ? wr_data : byp_val[p];
                byp_en[p+1] <= !reset && (hit[p] || byp_en[p]);
            end
        end
    end

    // The RAM is read one stage late so its data lines up with LAST
    bucket_ram #(
        .T_PAYLOAD   (T_PAYLOAD),
        .RESET_VALUE (RESET_VALUE)
    ) copy_ram (
        .clk   (clk),
        .reset (reset),
        .raddr (lk_idx[LAST-1]),
        .waddr (wr_idx),
        .wen   (wr_en),
        .wdata (wr_data),
        .rdata (ram_data)
    );

    assign result = byp_en[LAST] ? byp_val[LAST] : ram_data;

endmodule

`default_nettype wire

//--- design/counting_filter.sv
// ========================================================================
// Single-bank counting filter. Inserts apply at once, removes are credit
// controlled and lookups answer two cycles after the request.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

module counting_filter
    import filter_types_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           insert_en,
    input  t_bucket_idx   insert,
    input  wire           remove_en,
    input  t_bucket_idx   remove,
    output logic          remove_credit,
    input  t_bucket_idx   value_req,
    output t_bucket_value value_result,
    input  t_bucket_idx   zero_req,
    output logic          zero_result
);

    t_bucket_idx   remove_head;
    logic          remove_pending;
    logic          remove_take;
    logic          wr_en;
    t_bucket_idx   wr_idx;
    t_bucket_value wr_value;
    logic          wr_is_zero;

    remove_queue remove_q (
        .clk, .reset, .remove_en, .remove, .remove_take,
        .remove_head, .remove_pending, .remove_credit
    );

    count_update_pipe update_pipe (
        .clk, .reset, .insert_en, .insert, .remove_head, .remove_pending,
        .remove_take, .wr_en, .wr_idx, .wr_value, .wr_is_zero
    );

    // Counter value port
    bucket_lookup #(.T_PAYLOAD(t_bucket_value), .RESET_VALUE(t_bucket_value'(0))) value_lookup (
        .clk, .reset, .req(value_req), .wr_en, .wr_idx, .wr_data(wr_value),
        .result(value_result)
    );

    // Is-zero port keeps a one-bit copy, so every bucket starts empty
    bucket_lookup #(.T_PAYLOAD(logic), .RESET_VALUE(1'b1)) zero_lookup (
        .clk, .reset, .req(zero_req), .wr_en, .wr_idx, .wr_data(wr_is_zero),
        .result(zero_result)
    );

endmodule

`default_nettype wire

//--- verification/counting_filter_asserts.sv
// ========================================================================
// Protocol and range checks bound to the filter top level. Each write to
// a bucket differs from the last one by one, so a wrap shows as 0 <-> max.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_defs.svh"

module counting_filter_asserts
    import filter_types_pkg::*;
(
    input wire           clk,
    input wire           reset,
    input wire           remove_en,
    input wire           remove_take,
    input wire           remove_credit,
    input wire           wr_en,
    input t_bucket_idx   wr_idx,
    input t_bucket_value wr_value
);

    localparam int DEPTH = `FILTER_REMOVE_DEPTH;
    localparam t_bucket_value MAX_VALUE = '1;

    // Entries held by the remove queue
    int occupancy;
    // Last value written to each bucket
    t_bucket_value last_write [0:`FILTER_N_BUCKETS-1];
    logic wraps;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            occupancy <= 0;
            for (int i = 0; i < `FILTER_N_BUCKETS; i++)
            begin
                last_write[i] <= '0;
            end
        end
        else
        begin
            occupancy <= occupancy + int'(remove_en) - int'(remove_take);
            if (wr_en)
            begin
                last_write[wr_idx] <= wr_value;
            end
        end
    end

    assign wraps = ((last_write[wr_idx] == MAX_VALUE) && (wr_value == '0))
                || ((last_write[wr_idx] == '0) && (wr_value == MAX_VALUE));

    credit_low_in_reset: assert property (@(posedge clk) reset |=> !remove_credit)
        else $error("remove_credit high while in reset");

    queue_no_overflow: assert property (@(posedge clk) disable iff (reset)
        remove_en |-> (occupancy < DEPTH))
        else $error("remove queue written while full");

    bucket_no_wrap: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !wraps)
        else $error("bucket %0d wrapped on write", wr_idx);

endmodule

bind counting_filter counting_filter_asserts asserts0 (
    .clk           (clk),
    .reset         (reset),
    .remove_en     (remove_en),
    .remove_take   (remove_take),
    .remove_credit (remove_credit),
    .wr_en         (wr_en),
    .wr_idx        (wr_idx),
    .wr_value      (wr_value)
);

`default_nettype wire

//--- verification/counting_filter_tb.sv
// ========================================================================
// Self-checking testbench for the counting filter. Removes never exceed
// the credits held, and inserts stay low enough that no bucket overflows.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "counting_filter_defs.svh"

module counting_filter_tb
    import filter_types_pkg::*;
();

    localparam int N_BUCKETS = `FILTER_N_BUCKETS;
    localparam int DEPTH = `FILTER_REMOVE_DEPTH;
    localparam int MAX_COUNT = (1 << `FILTER_BUCKET_BITS) - 1;
    localparam int MIX_CYCLES = 2000;
    localparam int QUIET_EVERY = 250;
    // Directed parts, the mix and its quiet sweeps stay below this
    localparam int STIM_CYCLES = MIX_CYCLES + 400;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic          clk;
    logic          reset;
    logic          insert_en;
    t_bucket_idx   insert;
    logic          remove_en;
    t_bucket_idx   remove;
    logic          remove_credit;
    t_bucket_idx   value_req;
    t_bucket_value value_result;
    t_bucket_idx   zero_req;
    logic          zero_result;

    // Expected counts follow each insert and remove as it is issued
    int model [0:N_BUCKETS-1];
    int credits;
    int removes_sent;
    int credits_back;
    int errors;
    int checks;
    int cycle;
    integer seed;

    // Expectation for the lookup driven in the current cycle
    logic          exp_valid;
    t_bucket_value exp_value;
    logic          exp_zero;
    // The same expectation carried to the cycle its result appears
    logic          chk_q [0:1];
    t_bucket_value val_q [0:1];
    logic          zero_q [0:1];
    t_bucket_idx   idx_q [0:1];

    counting_filter dut0 (
        .clk, .reset, .insert_en, .insert, .remove_en, .remove, .remove_credit,
        .value_req, .value_result, .zero_req, .zero_result
    );

    always #4 clk = !clk;

    function automatic int expected_count(input t_bucket_idx b);
        return model[b];
    endfunction

    // Drives one cycle of stimulus on the falling edge
    task automatic drive_cycle(input logic ins_en, input t_bucket_idx ins_b,
                               input logic rem_en, input t_bucket_idx rem_b,
                               input t_bucket_idx lk_b);
        @(negedge clk);
        // The lookup sees every update issued before this cycle
        exp_valid = (credits == DEPTH);
        exp_value = t_bucket_value'(expected_count(lk_b));
        exp_zero = (expected_count(lk_b) == 0);
        value_req = lk_b;
        zero_req = lk_b;
        insert_en = ins_en;
        insert = ins_b;
        remove_en = rem_en;
        remove = rem_b;
        if (rem_en)
        begin
            credits--;
            removes_sent++;
            model[rem_b]--;
        end
        if (ins_en)
        begin
            model[ins_b]++;
        end
    endtask

    // Idles until every credit is back and then three cycles more
    task automatic wait_quiet();
        while (credits != DEPTH)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, '0);
        end
        repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic sweep_all();
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, t_bucket_idx'(b));
        end
        // Two more cycles bring out the last results
        repeat (2) drive_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    // Sends a single remove and looks the bucket up once its credit is home
    task automatic remove_paced(input t_bucket_idx b);
        drive_cycle(1'b0, '0, 1'b1, b, b);
        while (credits != DEPTH)
        begin
            drive_cycle(1'b0, '0, 1'b0, '0, b);
        end
        repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, b);
    endtask

    // ====================================================================
    // Compare process that runs two cycles behind each lookup request
    // ====================================================================

    always @(posedge clk)
    begin
        if (reset)
        begin
            chk_q[0] <= 1'b0;
            chk_q[1] <= 1'b0;
        end
        else
        begin
            if (chk_q[1])
            begin
                checks++;
                if (value_result !== val_q[1])
                begin
                    errors++;
                    $display("[FAIL] %0t ns value_result bucket %0d expected %0d got %0d",
                             $time, idx_q[1], val_q[1], value_result);
                end
                if (zero_result !== zero_q[1])
                begin
                    errors++;
                    $display("[FAIL] %0t ns zero_result bucket %0d expected %0b got %0b",
                             $time, idx_q[1], zero_q[1], zero_result);
                end
            end
            if (remove_credit)
            begin
                if (credits_back >= removes_sent)
                begin
                    errors++;
                    $display("A credit came back at %0t ns with no remove outstanding",
                             $time);
                end
                credits_back++;
                credits++;
            end
            chk_q[0] <= exp_valid;
            val_q[0] <= exp_value;
            zero_q[0] <= exp_zero;
            idx_q[0] <= value_req;
            chk_q[1] <= chk_q[0];
            val_q[1] <= val_q[0];
            zero_q[1] <= zero_q[0];
            idx_q[1] <= idx_q[0];
        end
    end

    always @(posedge clk)
    begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped by timeout after %0d cycles, %0d errors", cycle, errors);
            $display("** FAIL **");
            $finish;
        end
    end

    // ====================================================================
    // Stimulus
    // ====================================================================

    initial
    begin
        int r;
        int base;
        t_bucket_idx ib;
        t_bucket_idx rb;
        logic do_ins;
        logic do_rem;
        clk = 1'b0;
        reset = 1'b1;
        insert_en = 1'b0;
        insert = '0;
        remove_en = 1'b0;
        remove = '0;
        value_req = '0;
        zero_req = '0;
        exp_valid = 1'b0;
        exp_value = '0;
        exp_zero = 1'b1;
        seed = 32'h843f2bc6;
        credits = DEPTH;
        removes_sent = 0;
        credits_back = 0;
        errors = 0;
        checks = 0;
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            model[b] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Every bucket reads empty after reset
        sweep_all();

        // The lookup right behind three inserts in a row must see all of them
        repeat (3) drive_cycle(1'b1, t_bucket_idx'(3), 1'b0, '0, t_bucket_idx'(3));
        repeat (3) drive_cycle(1'b0, '0, 1'b0, '0, t_bucket_idx'(3));

        // Removes one at a time bring bucket 3 back to empty
        repeat (3) remove_paced(t_bucket_idx'(3));

        // Inserts hold off every queued remove until they stop
        repeat (DEPTH) drive_cycle(1'b1, t_bucket_idx'(1), 1'b0, '0, '0);
        base = credits_back;
        for (int i = 0; i < 12; i++)
        begin
            drive_cycle(1'b1, t_bucket_idx'(8 + i % 4), i < DEPTH, t_bucket_idx'(1),
                        t_bucket_idx'(8 + i % 4));
        end
        // A take in the last insert cycle would have its credit counted by now
        repeat (2) drive_cycle(1'b0, '0, 1'b0, '0, '0);
        if (credits_back != base)
        begin
            errors++;
            $display("A credit returned while inserts were still running");
        end
        wait_quiet();
        if (credits_back != base + DEPTH)
        begin
            errors++;
            $display("Not all queued removes returned a credit after the inserts");
        end
        sweep_all();

        // Random mix with a full sweep at regular quiet points
        for (int i = 0; i < MIX_CYCLES; i++)
        begin
            r = $random(seed);
            ib = t_bucket_idx'(r);
            rb = t_bucket_idx'(r >> 8);
            do_ins = r[20] && (model[ib] < MAX_COUNT - DEPTH);
            do_rem = r[21] && (credits > 0) && (model[rb] > 0);
            drive_cycle(do_ins, ib, do_rem, rb, t_bucket_idx'(r >> 16));
            if (i % QUIET_EVERY == QUIET_EVERY - 1)
            begin
                wait_quiet();
                sweep_all();
            end
        end

        wait_quiet();
        if (credits_back != removes_sent)
        begin
            errors++;
            $display("Sent %0d removes but got %0d credits back", removes_sent, credits_back);
        end
        $display("Lookups checked %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- counting_filter.f
+incdir+include
design/filter_types_pkg.sv
design/update_pipe_pkg.sv
design/remove_queue.sv
design/bucket_ram.sv
design/count_update_pipe.sv
design/bucket_lookup.sv
design/counting_filter.sv
verification/counting_filter_asserts.sv
verification/counting_filter_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = counting_filter_tb
FILELIST  = counting_filter.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
